/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width in bits.
`define RV_XLEN 32

// Number of architectural integer registers.
`define RV_NREGS 32

// First fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

/* common/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RS2 = 2'd0,
        SRC_B_IMM = 2'd1
    } src_b_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_IMM  = 2'd2,
        WB_PC4  = 2'd3
    } wb_sel_e;

    // An all-zero control word writes nothing and lets the PC advance by 4.
    typedef struct packed {
        logic                 jump;
        logic                 branch;
        logic                 mem_read;
        logic                 mem_write;
        logic                 rf_write;
        src_a_e               src_a;
        src_b_e               src_b;
        wb_sel_e              wb_sel;
        alu_op_e              alu_op;
        rv_isa_pkg::funct3_e  funct3;
    } ctrl_t;

endpackage

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Load and store widths share their encodings with the branch conditions,
    // so each name carries both meanings of the code.
    typedef enum logic [2:0] {
        F3_LB_BEQ  = 3'b000,
        F3_LH_BNE  = 3'b001,
        F3_LW      = 3'b010,
        F3_LBU_BLT = 3'b100,
        F3_LHU_BGE = 3'b101,
        F3_BLTU    = 3'b110,
        F3_BGEU    = 3'b111
    } funct3_e;

    // Field layout of an R-type word, most significant field first.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_fields_t;

endpackage

/* decode/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
    input  logic [`RV_XLEN-1:0]       instr,
    output rv_isa_pkg::instr_fields_t fields,
    output logic [`RV_XLEN-1:0]       imm,
    output rv_ctrl_pkg::ctrl_t        ctrl
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                alt_op;

    assign fields = rv_isa_pkg::instr_fields_t'(instr);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Bit 30 selects SUB over ADD and SRA over SRL.
    assign alt_op = instr[30];

    always_comb begin
        case (fields.opcode)
            rv_isa_pkg::OPC_STORE:  imm = imm_s;
            rv_isa_pkg::OPC_BRANCH: imm = imm_b;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:  imm = imm_u;
            rv_isa_pkg::OPC_JAL:    imm = imm_j;
            default:                imm = imm_i;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.funct3 = fields.funct3;

        case (fields.opcode)
            rv_isa_pkg::OPC_LUI: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = rv_ctrl_pkg::WB_IMM;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl.rf_write = 1'b1;
                ctrl.src_a    = rv_ctrl_pkg::SRC_A_PC;
                ctrl.src_b    = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.rf_write = 1'b1;
                ctrl.src_a    = rv_ctrl_pkg::SRC_A_PC;
                ctrl.src_b    = rv_ctrl_pkg::SRC_B_IMM;
                ctrl.wb_sel   = rv_ctrl_pkg::WB_PC4;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.jump     = 1'b1;
                ctrl.rf_write = 1'b1;
                ctrl.src_b    = rv_ctrl_pkg::SRC_B_IMM;
                ctrl.wb_sel   = rv_ctrl_pkg::WB_PC4;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl.branch = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.mem_read = 1'b1;
                ctrl.rf_write = 1'b1;
                ctrl.src_b    = rv_ctrl_pkg::SRC_B_IMM;
                ctrl.wb_sel   = rv_ctrl_pkg::WB_LOAD;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b     = rv_ctrl_pkg::SRC_B_IMM;
            end
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_OP: begin
                ctrl.rf_write = 1'b1;
                if (fields.opcode == rv_isa_pkg::OPC_OP_IMM) begin
                    ctrl.src_b = rv_ctrl_pkg::SRC_B_IMM;
                end
                case (fields.funct3)
                    3'b000: begin
                        // ADDI has no SUB form, so bit 30 only counts for OP.
                        if (alt_op && fields.opcode == rv_isa_pkg::OPC_OP) begin
                            ctrl.alu_op = rv_ctrl_pkg::ALU_SUB;
                        end else begin
                            ctrl.alu_op = rv_ctrl_pkg::ALU_ADD;
                        end
                    end
                    3'b001: ctrl.alu_op = rv_ctrl_pkg::ALU_SLL;
                    3'b010: ctrl.alu_op = rv_ctrl_pkg::ALU_SLT;
                    3'b011: ctrl.alu_op = rv_ctrl_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_op = rv_ctrl_pkg::ALU_XOR;
                    3'b101: begin
                        if (alt_op) begin
                            ctrl.alu_op = rv_ctrl_pkg::ALU_SRA;
                        end else begin
                            ctrl.alu_op = rv_ctrl_pkg::ALU_SRL;
                        end
                    end
                    3'b110: ctrl.alu_op = rv_ctrl_pkg::ALU_OR;
                    default: ctrl.alu_op = rv_ctrl_pkg::ALU_AND;
                endcase
            end
            default: begin
                // Unsupported opcodes fall through as a no-op.
            end
        endcase
    end

    always_comb begin
        assert final (!(ctrl.mem_read && ctrl.mem_write))
            else $error("Decoder raised load and store together for %h", instr);
    end

endmodule

/* execute/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute (
    input  rv_ctrl_pkg::ctrl_t  ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic                branch_taken
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic                cond;

    always_comb begin
        case (ctrl.src_a)
            rv_ctrl_pkg::SRC_A_RS1: op_a = rdata1;
            rv_ctrl_pkg::SRC_A_PC:  op_a = pc;
            default:                op_a = '0;
        endcase

        case (ctrl.src_b)
            rv_ctrl_pkg::SRC_B_IMM: op_b = imm;
            default:                op_b = rdata2;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_ctrl_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_ctrl_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_ctrl_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_ctrl_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            rv_ctrl_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_ctrl_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_ctrl_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_ctrl_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_ctrl_pkg::ALU_AND:  alu_result = op_a & op_b;
            default:               alu_result = op_a + op_b;
        endcase
    end

    // Branches compare the register values directly, not the ALU output.
    // Odd funct3 codes are the negated forms.
    always_comb begin
        case (ctrl.funct3)
            rv_isa_pkg::F3_LB_BEQ,
            rv_isa_pkg::F3_LH_BNE:  cond = (rdata1 == rdata2);
            rv_isa_pkg::F3_LBU_BLT,
            rv_isa_pkg::F3_LHU_BGE: cond = ($signed(rdata1) < $signed(rdata2));
            rv_isa_pkg::F3_BLTU,
            rv_isa_pkg::F3_BGEU:    cond = (rdata1 < rdata2);
            default:                cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.branch && (cond ^ ctrl.funct3[0]);

endmodule

/* fetch/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                jump,
    input  logic                branch_taken,
    input  logic [`RV_XLEN-1:0] jump_target,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pc_plus4
);

    logic [`RV_XLEN-1:0] next_pc;

    assign pc_plus4 = pc + `RV_XLEN'd4;

    // Jumps win over branches; JALR targets have bit 0 cleared.
    always_comb begin
        if (jump) begin
            next_pc = {jump_target[`RV_XLEN-1:1], 1'b0};
        end else if (branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("PC lost word alignment: %h", pc);

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
    input  logic                clk,
    input  logic                arst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic                dmem_we,
    output logic [3:0]          dmem_wmask,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    input  logic [`RV_XLEN-1:0] dmem_rdata
);

    rv_isa_pkg::instr_fields_t fields;
    rv_ctrl_pkg::ctrl_t        ctrl;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                branch_taken;

    assign imem_addr = pc;

    rv_fetch u_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .jump         (ctrl.jump),
        .branch_taken (branch_taken),
        .jump_target  (alu_result),
        .imm          (imm),
        .pc           (pc),
        .pc_plus4     (pc_plus4)
    );

    rv_decode u_decode (
        .instr  (imem_rdata),
        .fields (fields),
        .imm    (imm),
        .ctrl   (ctrl)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (fields.rs1),
        .rs2    (fields.rs2),
        .rd     (fields.rd),
        .we     (ctrl.rf_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute u_execute (
        .ctrl         (ctrl),
        .pc           (pc),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .imm          (imm),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    rv_lsu u_lsu (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .store_data (rdata2),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            rv_ctrl_pkg::WB_LOAD: wb_data = load_data;
            rv_ctrl_pkg::WB_IMM:  wb_data = imm;
            rv_ctrl_pkg::WB_PC4:  wb_data = pc_plus4;
            default:              wb_data = alu_result;
        endcase
    end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is hardwired to zero on both read ports.
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* memory/rv_lsu.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_lsu (
    input  rv_ctrl_pkg::ctrl_t  ctrl,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] store_data,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic                dmem_we,
    output logic [3:0]          dmem_wmask,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic [`RV_XLEN-1:0] load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        misaligned;

    assign dmem_addr = {addr[`RV_XLEN-1:2], 2'b00};
    assign dmem_we   = ctrl.mem_write;

    // Store data is replicated over every lane; the mask picks the lanes written.
    always_comb begin
        case (ctrl.funct3)
            rv_isa_pkg::F3_LB_BEQ: begin
                dmem_wdata = {4{store_data[7:0]}};
                dmem_wmask = 4'b0001 << addr[1:0];
            end
            rv_isa_pkg::F3_LH_BNE: begin
                dmem_wdata = {2{store_data[15:0]}};
                dmem_wmask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_wdata = store_data;
                dmem_wmask = 4'b1111;
            end
        endcase
        if (!ctrl.mem_write) begin
            dmem_wmask = 4'b0000;
        end
    end

    assign load_byte = dmem_rdata[8*addr[1:0] +: 8];
    assign load_half = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (ctrl.funct3)
            rv_isa_pkg::F3_LB_BEQ:  load_data = {{24{load_byte[7]}}, load_byte};
            rv_isa_pkg::F3_LH_BNE:  load_data = {{16{load_half[15]}}, load_half};
            rv_isa_pkg::F3_LBU_BLT: load_data = {24'b0, load_byte};
            rv_isa_pkg::F3_LHU_BGE: load_data = {16'b0, load_half};
            default:                load_data = dmem_rdata;
        endcase
    end

    always_comb begin
        case (ctrl.funct3)
            rv_isa_pkg::F3_LH_BNE,
            rv_isa_pkg::F3_LHU_BGE: misaligned = addr[0];
            rv_isa_pkg::F3_LW:      misaligned = (addr[1:0] != 2'b00);
            default:                misaligned = 1'b0;
        endcase
    end

    // Misaligned accesses are not split, so the address from execute must fit the width.
    always_comb begin
        assert final (!((ctrl.mem_read || ctrl.mem_write) && misaligned))
            else $error("Misaligned data access at %h", addr);
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_rv_core -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"
exit 0

/* sim.f */
+incdir+common
+incdir+tests
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
fetch/rv_fetch.sv
decode/rv_decode.sv
logic/rv_regfile.sv
execute/rv_execute.sv
memory/rv_lsu.sv
logic/rv_core.sv
tests/tb_rv_core.sv

/* tests/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each expected store holds the word address, the byte-lane mask and the write data.
typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
} store_t;

function automatic logic [31:0] encode_r(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] encode_i(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic logic [31:0] encode_s(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encode_b(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encode_u(input int imm20, input int rd, input logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encode_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// Words are pushed in order, so the queue index is the word address.
task automatic load_program(ref logic [31:0] prog [$]);
    logic [31:0] poison;
    logic [31:0] count_up;
    poison   = encode_s(124, 4, 0, 3'b010);
    count_up = encode_i(1, 21, 3'b000, 21, 7'h13);
    prog.push_back(encode_u(32'h12345, 1, 7'h37));
    prog.push_back(encode_s(0, 1, 0, 3'b010));
    prog.push_back(encode_u(1, 2, 7'h17));
    prog.push_back(encode_s(4, 2, 0, 3'b010));
    prog.push_back(encode_i(-5, 0, 3'b000, 3, 7'h13));
    prog.push_back(encode_i(7, 0, 3'b000, 4, 7'h13));
    prog.push_back(encode_r(7'h20, 3, 4, 3'b000, 5));
    prog.push_back(encode_s(8, 5, 0, 3'b010));
    prog.push_back(encode_i(32'h401, 3, 3'b101, 6, 7'h13));
    prog.push_back(encode_s(12, 6, 0, 3'b010));
    prog.push_back(encode_i(4, 3, 3'b101, 7, 7'h13));
    prog.push_back(encode_s(16, 7, 0, 3'b010));
    prog.push_back(encode_r(7'h00, 4, 4, 3'b001, 8));
    prog.push_back(encode_s(20, 8, 0, 3'b010));
    prog.push_back(encode_r(7'h00, 4, 3, 3'b010, 9));
    prog.push_back(encode_r(7'h00, 4, 3, 3'b011, 10));
    prog.push_back(encode_s(24, 9, 0, 3'b010));
    prog.push_back(encode_s(28, 10, 0, 3'b010));
    prog.push_back(encode_r(7'h00, 4, 3, 3'b100, 11));
    prog.push_back(encode_s(32, 11, 0, 3'b010));
    prog.push_back(encode_r(7'h00, 4, 3, 3'b110, 12));
    prog.push_back(encode_s(36, 12, 0, 3'b010));
    prog.push_back(encode_r(7'h00, 4, 3, 3'b111, 13));
    prog.push_back(encode_s(40, 13, 0, 3'b010));
    // Loads from the preloaded word at 0x80.
    prog.push_back(encode_i(32'h80, 0, 3'b000, 14, 7'h13));
    prog.push_back(encode_i(0, 14, 3'b000, 15, 7'h03));
    prog.push_back(encode_s(44, 15, 0, 3'b010));
    prog.push_back(encode_i(3, 14, 3'b100, 16, 7'h03));
    prog.push_back(encode_s(48, 16, 0, 3'b010));
    prog.push_back(encode_i(2, 14, 3'b001, 17, 7'h03));
    prog.push_back(encode_s(52, 17, 0, 3'b010));
    prog.push_back(encode_i(0, 14, 3'b101, 18, 7'h03));
    prog.push_back(encode_s(56, 18, 0, 3'b010));
    prog.push_back(encode_i(0, 14, 3'b010, 19, 7'h03));
    prog.push_back(encode_s(60, 19, 0, 3'b010));
    prog.push_back(encode_s(64, 19, 0, 3'b000));
    prog.push_back(encode_s(65, 19, 0, 3'b000));
    prog.push_back(encode_s(66, 19, 0, 3'b000));
    prog.push_back(encode_s(67, 19, 0, 3'b000));
    prog.push_back(encode_s(68, 19, 0, 3'b001));
    prog.push_back(encode_s(70, 19, 0, 3'b001));
    prog.push_back(encode_i(99, 0, 3'b000, 0, 7'h13));
    prog.push_back(encode_s(72, 0, 0, 3'b010));
    // Taken branches skip a store to 0x7C.
    prog.push_back(encode_b(8, 4, 4, 3'b000));
    prog.push_back(poison);
    prog.push_back(encode_b(8, 4, 3, 3'b001));
    prog.push_back(poison);
    prog.push_back(encode_b(8, 4, 3, 3'b100));
    prog.push_back(poison);
    prog.push_back(encode_b(8, 3, 4, 3'b101));
    prog.push_back(poison);
    prog.push_back(encode_b(8, 3, 4, 3'b110));
    prog.push_back(poison);
    prog.push_back(encode_b(8, 4, 3, 3'b111));
    prog.push_back(poison);
    // Branches that fall through each count x21 up once.
    prog.push_back(encode_b(8, 4, 3, 3'b000));
    prog.push_back(count_up);
    prog.push_back(encode_b(8, 4, 4, 3'b001));
    prog.push_back(count_up);
    prog.push_back(encode_b(8, 3, 4, 3'b100));
    prog.push_back(count_up);
    prog.push_back(encode_b(8, 4, 3, 3'b101));
    prog.push_back(count_up);
    prog.push_back(encode_b(8, 4, 3, 3'b110));
    prog.push_back(count_up);
    prog.push_back(encode_b(8, 3, 4, 3'b111));
    prog.push_back(count_up);
    prog.push_back(encode_s(76, 21, 0, 3'b010));
    // JAL sits at 0x110, JALR at 0x11C with an odd offset to land on 0x124.
    prog.push_back(encode_j(8, 22));
    prog.push_back(poison);
    prog.push_back(encode_s(80, 22, 0, 3'b010));
    prog.push_back(encode_i(17, 22, 3'b000, 24, 7'h67));
    prog.push_back(poison);
    prog.push_back(encode_s(84, 24, 0, 3'b010));
    prog.push_back(encode_j(0, 0));
endtask

task automatic load_expected(ref store_t stores [$]);
    stores.push_back({32'h00, 4'hF, 32'h1234_5000});
    stores.push_back({32'h04, 4'hF, 32'h0000_1008});
    stores.push_back({32'h08, 4'hF, 32'h0000_000C});
    stores.push_back({32'h0C, 4'hF, 32'hFFFF_FFFD});
    stores.push_back({32'h10, 4'hF, 32'h0FFF_FFFF});
    stores.push_back({32'h14, 4'hF, 32'h0000_0380});
    stores.push_back({32'h18, 4'hF, 32'h0000_0001});
    stores.push_back({32'h1C, 4'hF, 32'h0000_0000});
    stores.push_back({32'h20, 4'hF, 32'hFFFF_FFFC});
    stores.push_back({32'h24, 4'hF, 32'hFFFF_FFFF});
    stores.push_back({32'h28, 4'hF, 32'h0000_0003});
    stores.push_back({32'h2C, 4'hF, 32'hFFFF_FF82});
    stores.push_back({32'h30, 4'hF, 32'h0000_0080});
    stores.push_back({32'h34, 4'hF, 32'hFFFF_80F1});
    stores.push_back({32'h38, 4'hF, 32'h0000_7F82});
    stores.push_back({32'h3C, 4'hF, 32'h80F1_7F82});
    stores.push_back({32'h40, 4'h1, 32'h8282_8282});
    stores.push_back({32'h40, 4'h2, 32'h8282_8282});
    stores.push_back({32'h40, 4'h4, 32'h8282_8282});
    stores.push_back({32'h40, 4'h8, 32'h8282_8282});
    stores.push_back({32'h44, 4'h3, 32'h7F82_7F82});
    stores.push_back({32'h44, 4'hC, 32'h7F82_7F82});
    stores.push_back({32'h48, 4'hF, 32'h0000_0000});
    stores.push_back({32'h4C, 4'hF, 32'h0000_0006});
    stores.push_back({32'h50, 4'hF, 32'h0000_0114});
    stores.push_back({32'h54, 4'hF, 32'h0000_0120});
endtask

`endif

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

    `include "tb_program.svh"

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic        dmem_we;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;

    logic [31:0] prog [$];
    store_t      exp_stores [$];
    logic [31:0] mem [64];
    int          value_errors;
    int          other_errors;

    rv_core UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    assign dmem_rdata = mem[dmem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        // Beyond the program the core spins on a jump to itself.
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return 32'h0000_006F;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        value_errors++;
    endtask

    initial begin
        logic [31:0] last_pc;
        logic [31:0] next_pc;
        logic        done;
        logic        write_pending;
        logic        exp_we;
        store_t      seen;
        int          store_idx;
        int          cycles;

        arst_n        = 1'b0;
        imem_rdata    = '0;
        value_errors  = 0;
        other_errors  = 0;
        store_idx     = 0;
        done          = 1'b0;
        write_pending = 1'b0;
        seen          = '0;
        load_program(prog);
        load_expected(exp_stores);
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hD000_0000 | (i << 2);
        end
        mem[32] = 32'h80F1_7F82;

        repeat (2) begin
            @(posedge clk);
            if (dmem_we !== 1'b0) begin
                report_mismatch("dmem_we", 32'h0, {31'b0, dmem_we});
            end
        end
        @(negedge clk);
        arst_n = 1'b1;
        if (imem_addr !== `RV_RESET_PC) begin
            report_mismatch("imem_addr", `RV_RESET_PC, imem_addr);
        end
        last_pc = imem_addr;

        for (cycles = 0; cycles < 500 && !done; cycles++) begin
            imem_rdata = fetch_word(imem_addr);
            #25;
            exp_we = (imem_rdata[6:0] == 7'b0100011);
            if (dmem_we !== exp_we) begin
                report_mismatch("dmem_we", {31'b0, exp_we}, {31'b0, dmem_we});
            end
            write_pending = dmem_we;
            if (dmem_we === 1'b1) begin
                seen = {dmem_addr, dmem_wmask, dmem_wdata};
                if (store_idx >= exp_stores.size()) begin
                    $display("Unexpected store to address %h at %0t", dmem_addr, $time);
                    other_errors++;
                end else begin
                    if (seen.addr !== exp_stores[store_idx].addr) begin
                        report_mismatch("dmem_addr", exp_stores[store_idx].addr, seen.addr);
                    end
                    if (seen.mask !== exp_stores[store_idx].mask) begin
                        report_mismatch("dmem_wmask", {28'b0, exp_stores[store_idx].mask},
                                        {28'b0, seen.mask});
                    end
                    if (seen.data !== exp_stores[store_idx].data) begin
                        report_mismatch("dmem_wdata", exp_stores[store_idx].data, seen.data);
                    end
                end
                store_idx++;
            end
            @(posedge clk);
            if (write_pending) begin
                for (int b = 0; b < 4; b++) begin
                    if (seen.mask[b]) begin
                        mem[seen.addr[7:2]][8*b +: 8] = seen.data[8*b +: 8];
                    end
                end
            end
            @(negedge clk);
            next_pc = imem_addr;
            if (next_pc == last_pc) begin
                done = 1'b1;
            end
            last_pc = next_pc;
        end

        if (!done) begin
            $display("Timeout: the program never reached its final self-loop");
            other_errors++;
        end
        if (store_idx < exp_stores.size()) begin
            $display("Missing stores: saw %0d of %0d", store_idx, exp_stores.size());
            other_errors++;
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
